/* verilog/ntm_num_pkg.sv */
package ntm_num_pkg;

  ////////////////////////////////////////
  // Fixed point format
  ////////////////////////////////////////

  // Q2.14 data word used for m, w, e, keep and the result
  typedef logic signed [15:0] fix_t;

  // Full 16x16 product, before rounding back to Q2.14
  typedef logic signed [31:0] prod_t;

  ////////////////////////////////////////
  // Constants
  ////////////////////////////////////////

  // Fraction bits of fix_t
  localparam int FIX_FRAC = 14;

  // 1.0 in Q2.14
  localparam fix_t FIX_ONE = fix_t'(16384);

  // Half an LSB of the result, added before the arithmetic shift
  localparam prod_t FIX_HALF_LSB = prod_t'(8192);

endpackage

/* verilog/ntm_erase_pkg.sv */
package ntm_erase_pkg;

  ////////////////////////////////////////
  // Sizes and indices
  ////////////////////////////////////////

  // Largest row width W, also depth of the erase vector bank
  localparam int MAX_W = 8;

  // Column index k, 0 to MAX_W-1
  typedef logic [2:0] col_idx_t;

  // Row width, legal 1 to MAX_W
  typedef logic [3:0] width_t;

  // Row count N, legal 1 to 255
  typedef logic [7:0] row_cnt_t;

  // Sequencer FSM
  typedef enum logic [1:0] {
    IDLE,
    LOAD_ERASE,
    ERASE_ROWS
  } seq_state_t;

  ////////////////////////////////////////
  // Pipeline beats
  ////////////////////////////////////////

  // Accepted memory element, w already held for the row
  typedef struct packed {
    ntm_num_pkg::fix_t m;
    ntm_num_pkg::fix_t w;
    col_idx_t          k;
    logic              row_end;
    logic              last;
  } seq_beat_t;

  // Beat with e(k) looked up
  typedef struct packed {
    ntm_num_pkg::fix_t m;
    ntm_num_pkg::fix_t w;
    ntm_num_pkg::fix_t e_k;
    logic              row_end;
    logic              last;
  } erase_beat_t;

  // Beat with the clamped complement 1 - w*e(k)
  typedef struct packed {
    ntm_num_pkg::fix_t m;
    ntm_num_pkg::fix_t keep;
    logic              row_end;
    logic              last;
  } scale_beat_t;

  // Erased memory element
  typedef struct packed {
    ntm_num_pkg::fix_t m;
    logic              row_end;
    logic              last;
  } out_beat_t;

endpackage

/* verilog/erase_sequencer.sv */
`timescale 1ns/1ps

module erase_sequencer (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     start,
  input  ntm_erase_pkg::row_cnt_t  size_n,
  input  ntm_erase_pkg::width_t    size_w,
  input  logic                     e_in_enable,
  input  logic                     m_in_enable,
  input  ntm_num_pkg::fix_t        m_in,
  input  ntm_num_pkg::fix_t        w_in,
  input  logic                     out_valid,
  input  logic                     out_last,
  output logic                     e_wr_enable,
  output ntm_erase_pkg::col_idx_t  e_wr_index,
  output logic                     busy,
  output logic                     ready,
  output logic                     beat_valid,
  output ntm_erase_pkg::seq_beat_t beat
);

  import ntm_num_pkg::*;
  import ntm_erase_pkg::*;

  seq_state_t state;

  // Sizes latched on start
  row_cnt_t   size_n_q;
  width_t     size_w_q;

  // Position inside the matrix
  col_idx_t   col;
  row_cnt_t   row;

  // Row weight, sampled on k == 0
  fix_t       w_hold;

  // Last beats accepted but not yet out of the scale stage
  logic [1:0] drain_cnt;

  logic       start_ok;
  logic       col_last;
  logic       row_last;
  logic       last_accept;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // Start only counts in IDLE
  assign start_ok    = (state == IDLE) && start;
  assign col_last    = ({1'b0, col} == size_w_q - width_t'(1));
  assign row_last    = (row == size_n_q - row_cnt_t'(1));
  assign last_accept = beat_valid && beat.last;

  // Write port of the erase vector bank
  assign e_wr_enable = (state == LOAD_ERASE) && e_in_enable;
  assign e_wr_index  = col;

  // Memory beat, no added latency
  assign beat_valid  = (state == ERASE_ROWS) && m_in_enable;

  always_comb begin
    beat.m       = m_in;
    // First element of a row brings its own weight
    beat.w       = (col == '0) ? w_in : w_hold;
    beat.k       = col;
    beat.row_end = col_last;
    beat.last    = col_last && row_last;
  end

  ////////////////////////////////////////
  // FSM and counters
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= IDLE;
      size_n_q <= '0;
      size_w_q <= '0;
      col      <= '0;
      row      <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            size_n_q <= size_n;
            size_w_q <= size_w;
            col      <= '0;
            row      <= '0;
            state    <= LOAD_ERASE;
          end
        end
        LOAD_ERASE: begin
          // One e(k) per strobe
          if (e_in_enable) begin
            if (col_last) begin
              col   <= '0;
              state <= ERASE_ROWS;
            end else begin
              col <= col + col_idx_t'(1);
            end
          end
        end
        ERASE_ROWS: begin
          if (m_in_enable) begin
            if (col_last) begin
              col <= '0;
              if (row_last) begin
                row   <= '0;
                state <= IDLE;
              end else begin
                row <= row + row_cnt_t'(1);
              end
            end else begin
              col <= col + col_idx_t'(1);
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (beat_valid && (col == '0)) begin
      w_hold <= w_in;
    end
  end

  ////////////////////////////////////////
  // Busy and ready
  ////////////////////////////////////////

  // Final beat leaving the scale stage
  assign ready = out_valid && out_last;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      drain_cnt <= '0;
    end else begin
      drain_cnt <= drain_cnt + {1'b0, last_accept} - {1'b0, ready};
    end
  end

  // Covers the drain after the FSM is back in IDLE
  assign busy = (state != IDLE) || (drain_cnt != '0);

  // Zero or oversized width would never leave LOAD_ERASE cleanly
  a_start_width : assert property (@(posedge CLK) disable iff (RST)
    start_ok |-> (size_w != '0) && (size_w <= width_t'(MAX_W)));

  // k stays below the latched width, hence below MAX_W
  a_col_range : assert property (@(posedge CLK) disable iff (RST)
    (state != IDLE) |-> ({1'b0, col} < size_w_q));

  // A last beat out of the pipe was accepted here earlier
  a_ready_owned : assert property (@(posedge CLK) disable iff (RST)
    ready |-> (drain_cnt != '0));

endmodule

/* verilog/erase_vector_store.sv */
`timescale 1ns/1ps

module erase_vector_store (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       e_wr_enable,
  input  ntm_erase_pkg::col_idx_t    e_wr_index,
  input  ntm_num_pkg::fix_t          e_in,
  input  logic                       beat_valid,
  input  ntm_erase_pkg::seq_beat_t   beat,
  output logic                       erase_valid,
  output ntm_erase_pkg::erase_beat_t erase_beat
);

  import ntm_num_pkg::*;
  import ntm_erase_pkg::*;

  // Erase vector e, one word per column
  fix_t e_reg [MAX_W];

  ////////////////////////////////////////
  // Register bank
  ////////////////////////////////////////

  // Loaded only in LOAD_ERASE, so never read in the same cycle
  always_ff @(posedge CLK) begin
    if (e_wr_enable) begin
      e_reg[e_wr_index] <= e_in;
    end
  end

  ////////////////////////////////////////
  // Lookup stage
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      erase_valid <= 1'b0;
    end else begin
      erase_valid <= beat_valid;
    end
  end

  // Attach e(k) to the beat
  always_ff @(posedge CLK) begin
    if (beat_valid) begin
      erase_beat.m       <= beat.m;
      erase_beat.w       <= beat.w;
      erase_beat.e_k     <= e_reg[beat.k];
      erase_beat.row_end <= beat.row_end;
      erase_beat.last    <= beat.last;
    end
  end

endmodule

/* verilog/erase_weight_stage.sv */
`timescale 1ns/1ps

module erase_weight_stage (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       erase_valid,
  input  ntm_erase_pkg::erase_beat_t erase_beat,
  output logic                       scale_valid,
  output ntm_erase_pkg::scale_beat_t scale_beat
);

  import ntm_num_pkg::*;
  import ntm_erase_pkg::*;

  fix_t  w_s;
  fix_t  e_s;
  prod_t prod;
  prod_t prod_rnd;
  prod_t comp;
  fix_t  keep_c;
  fix_t  keep_q;

  ////////////////////////////////////////
  // 1 - w*e(k)
  ////////////////////////////////////////

  // Named signed operands so the product sign extends
  assign w_s      = erase_beat.w;
  assign e_s      = erase_beat.e_k;
  assign prod     = w_s * e_s;
  // Round half up, back to Q2.14
  assign prod_rnd = (prod + FIX_HALF_LSB) >>> FIX_FRAC;
  assign comp     = FIX_ONE - prod_rnd;

  // Clamp to [0, 1.0]
  always_comb begin
    if (comp < 0) begin
      keep_c = '0;
    end else if (comp > FIX_ONE) begin
      keep_c = FIX_ONE;
    end else begin
      keep_c = fix_t'(comp);
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      scale_valid <= 1'b0;
    end else begin
      scale_valid <= erase_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (erase_valid) begin
      scale_beat.m       <= erase_beat.m;
      scale_beat.keep    <= keep_c;
      scale_beat.row_end <= erase_beat.row_end;
      scale_beat.last    <= erase_beat.last;
    end
  end

  assign keep_q = scale_beat.keep;

  // Every looked-up beat leaves here with keep in [0, 1.0]
  a_keep_range : assert property (@(posedge CLK) disable iff (RST)
    erase_valid |=> scale_valid && (keep_q >= 0) && (keep_q <= FIX_ONE));

endmodule

/* verilog/memory_scale_stage.sv */
`timescale 1ns/1ps

module memory_scale_stage (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       scale_valid,
  input  ntm_erase_pkg::scale_beat_t scale_beat,
  output logic                       out_valid,
  output ntm_erase_pkg::out_beat_t   out_beat
);

  import ntm_num_pkg::*;
  import ntm_erase_pkg::*;

  fix_t  m_s;
  fix_t  keep_s;
  prod_t prod;
  prod_t prod_rnd;

  ////////////////////////////////////////
  // m * keep
  ////////////////////////////////////////

  assign m_s      = scale_beat.m;
  assign keep_s   = scale_beat.keep;
  assign prod     = m_s * keep_s;
  // keep <= 1.0 so the rounded result fits fix_t, no saturation
  assign prod_rnd = (prod + FIX_HALF_LSB) >>> FIX_FRAC;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= scale_valid;
    end
  end

  // Row flags pass straight through
  always_ff @(posedge CLK) begin
    if (scale_valid) begin
      out_beat.m       <= fix_t'(prod_rnd);
      out_beat.row_end <= scale_beat.row_end;
      out_beat.last    <= scale_beat.last;
    end
  end

endmodule

/* verilog/ntm_erase_top.sv */
`timescale 1ns/1ps

module ntm_erase_top (
  input  logic                    CLK,
  input  logic                    RST,
  input  logic                    start,
  input  ntm_erase_pkg::row_cnt_t size_n,
  input  ntm_erase_pkg::width_t   size_w,
  input  logic                    e_in_enable,
  input  ntm_num_pkg::fix_t       e_in,
  input  logic                    m_in_enable,
  input  ntm_num_pkg::fix_t       m_in,
  input  ntm_num_pkg::fix_t       w_in,
  output logic                    m_out_enable,
  output ntm_num_pkg::fix_t       m_out,
  output logic                    m_out_row_end,
  output logic                    ready,
  output logic                    busy
);

  import ntm_erase_pkg::*;

  // Erase vector write port
  logic        e_wr_enable;
  col_idx_t    e_wr_index;

  // Pipeline, sequencer -> store -> weight -> scale
  logic        beat_valid;
  seq_beat_t   beat;
  logic        erase_valid;
  erase_beat_t erase_beat;
  logic        scale_valid;
  scale_beat_t scale_beat;
  logic        out_valid;
  out_beat_t   out_beat;

  erase_sequencer u_erase_sequencer (
    .CLK         (CLK),
    .RST         (RST),
    .start       (start),
    .size_n      (size_n),
    .size_w      (size_w),
    .e_in_enable (e_in_enable),
    .m_in_enable (m_in_enable),
    .m_in        (m_in),
    .w_in        (w_in),
    .out_valid   (out_valid),
    .out_last    (out_beat.last),
    .e_wr_enable (e_wr_enable),
    .e_wr_index  (e_wr_index),
    .busy        (busy),
    .ready       (ready),
    .beat_valid  (beat_valid),
    .beat        (beat)
  );

  erase_vector_store u_erase_vector_store (
    .CLK         (CLK),
    .RST         (RST),
    .e_wr_enable (e_wr_enable),
    .e_wr_index  (e_wr_index),
    .e_in        (e_in),
    .beat_valid  (beat_valid),
    .beat        (beat),
    .erase_valid (erase_valid),
    .erase_beat  (erase_beat)
  );

  erase_weight_stage u_erase_weight_stage (
    .CLK         (CLK),
    .RST         (RST),
    .erase_valid (erase_valid),
    .erase_beat  (erase_beat),
    .scale_valid (scale_valid),
    .scale_beat  (scale_beat)
  );

  memory_scale_stage u_memory_scale_stage (
    .CLK         (CLK),
    .RST         (RST),
    .scale_valid (scale_valid),
    .scale_beat  (scale_beat),
    .out_valid   (out_valid),
    .out_beat    (out_beat)
  );

  // Output beat
  assign m_out_enable  = out_valid;
  assign m_out         = out_beat.m;
  // Flag only means something on a valid beat
  assign m_out_row_end = out_valid && out_beat.row_end;

endmodule

/* tests/ntm_erase_tb.sv */
`timescale 1ns/1ps

module ntm_erase_tb;

  import ntm_num_pkg::*;
  import ntm_erase_pkg::*;

  // One row of the test table
  typedef struct {
    int n;
    int w;
    int mode;
    int gap;
    int strays;
  } test_t;

  // Expected output beat
  typedef struct {
    int m;
    int row_end;
    int last;
  } exp_beat_t;

  localparam int NUM_TESTS     = 7;
  localparam int READY_TIMEOUT = 2000;

  // Value modes
  localparam int MODE_IN  = 0;
  localparam int MODE_OUT = 1;
  localparam int MODE_EXT = 2;

  // Gap patterns between strobes
  localparam int GAP_NONE = 0;
  localparam int GAP_ONE  = 1;
  localparam int GAP_RAND = 2;

  logic     CLK;
  logic     RST;
  logic     start;
  row_cnt_t size_n;
  width_t   size_w;
  logic     e_in_enable;
  fix_t     e_in;
  logic     m_in_enable;
  fix_t     m_in;
  fix_t     w_in;
  logic     m_out_enable;
  fix_t     m_out;
  logic     m_out_row_end;
  logic     ready;
  logic     busy;

  test_t       tests [NUM_TESTS];
  exp_beat_t   exp_q [$];
  int          cyc_q [$];
  int          cyc = 0;
  int          errors = 0;
  int          out_cnt = 0;
  int          ready_cnt = 0;
  int          tests_ok = 0;
  int          tests_bad = 0;
  bit          timed_out = 0;
  logic [31:0] lcg_state = 32'h51b8;

  ntm_erase_top u_ntm_erase_top (
    .CLK           (CLK),
    .RST           (RST),
    .start         (start),
    .size_n        (size_n),
    .size_w        (size_w),
    .e_in_enable   (e_in_enable),
    .e_in          (e_in),
    .m_in_enable   (m_in_enable),
    .m_in          (m_in),
    .w_in          (w_in),
    .m_out_enable  (m_out_enable),
    .m_out         (m_out),
    .m_out_row_end (m_out_row_end),
    .ready         (ready),
    .busy          (busy)
  );

  // 4 ns clock
  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  always @(posedge CLK) cyc <= cyc + 1;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  // LCG, upper half of the state is the usable part
  function automatic int next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return int'(lcg_state[31:16]);
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    int unsigned span;
    span = hi - lo + 1;
    return lo + int'(next_rand() % span);
  endfunction

  function automatic int gen_weight(input int mode);
    if (mode == MODE_IN) return rand_range(0, 16384);
    else if (mode == MODE_OUT) return rand_range(-32768, -1);
    else return rand_range(32000, 32767);
  endfunction

  function automatic int gen_erase(input int mode);
    if (mode == MODE_IN) return rand_range(0, 16384);
    else if (mode == MODE_OUT) return rand_range(0, 32767);
    else return rand_range(32000, 32767);
  endfunction

  function automatic int gen_mem(input int mode);
    int pick;
    pick = rand_range(0, 2);
    // Extreme mode favors the end points of the range
    if (mode == MODE_EXT && pick == 0) return -32768;
    else if (mode == MODE_EXT && pick == 1) return 32767;
    else return rand_range(-32768, 32767);
  endfunction

  // Model of 1 - w*e with round half up and clamp to [0, 1.0]
  function automatic int model_keep(input int w, input int e);
    int prod;
    int comp;
    prod = (w * e + int'(FIX_HALF_LSB)) >>> FIX_FRAC;
    comp = int'(FIX_ONE) - prod;
    if (comp < 0) return 0;
    else if (comp > int'(FIX_ONE)) return int'(FIX_ONE);
    else return comp;
  endfunction

  // Model of m * keep, rounded the same way
  function automatic int model_scale(input int m, input int keep);
    return (m * keep + int'(FIX_HALF_LSB)) >>> FIX_FRAC;
  endfunction

  task automatic check_value(input string what, input logic signed [31:0] got, input int exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  // Next drive point, strobes default low
  task automatic step();
    @(posedge CLK);
    #1;
    start       = 1'b0;
    e_in_enable = 1'b0;
    m_in_enable = 1'b0;
  endtask

  task automatic insert_gap(input int pattern);
    int len;
    if (pattern == GAP_ONE) len = 1;
    else if (pattern == GAP_RAND) len = rand_range(0, 3);
    else len = 0;
    repeat (len) step();
  endtask

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  // Sampled mid cycle, away from the edge
  always @(negedge CLK) begin : out_monitor
    exp_beat_t eb;
    int        c;
    if (!RST) begin
      if (m_out_enable) begin
        out_cnt++;
        if (exp_q.size() == 0) begin
          $display("ERROR at %0t ns: output beat with nothing expected", $time);
          errors++;
        end else begin
          eb = exp_q.pop_front();
          c  = cyc_q.pop_front();
          check_value("m_out", m_out, eb.m);
          check_value("m_out_row_end", m_out_row_end, eb.row_end);
          check_value("ready", ready, eb.last);
          check_value("latency", cyc - c, 3);
        end
      end else if (ready) begin
        $display("ERROR at %0t ns: ready pulse without an output beat", $time);
        errors++;
      end
      if (ready) ready_cnt++;
    end
  end

  ////////////////////////////////////////
  // One test run
  ////////////////////////////////////////

  task automatic run_test(input int t);
    test_t     tc;
    exp_beat_t eb;
    int        e_vec [MAX_W];
    int        w_row;
    int        m_val;
    int        beat_idx;
    int        waited;
    tc        = tests[t];
    beat_idx  = 0;
    out_cnt   = 0;
    ready_cnt = 0;
    // m_in_enable while idle
    for (int s = 0; s < tc.strays; s++) begin
      step();
      m_in_enable = 1'b1;
      m_in        = fix_t'(next_rand());
    end
    step();
    start  = 1'b1;
    size_n = row_cnt_t'(tc.n);
    size_w = width_t'(tc.w);
    // m_in_enable while loading
    for (int s = 0; s < tc.strays; s++) begin
      step();
      m_in_enable = 1'b1;
      m_in        = fix_t'(next_rand());
    end
    for (int k = 0; k < tc.w; k++) begin
      insert_gap(tc.gap);
      e_vec[k] = gen_erase(tc.mode);
      step();
      e_in_enable = 1'b1;
      e_in        = fix_t'(e_vec[k]);
    end
    // Last e strobe not taken yet
    check_value("busy while loading", busy, 1);
    for (int j = 0; j < tc.n; j++) begin
      for (int k = 0; k < tc.w; k++) begin
        insert_gap(tc.gap);
        if (k == 0) w_row = gen_weight(tc.mode);
        m_val      = gen_mem(tc.mode);
        eb.m       = model_scale(m_val, model_keep(w_row, e_vec[k]));
        eb.row_end = (k == tc.w - 1);
        eb.last    = eb.row_end && (j == tc.n - 1);
        step();
        exp_q.push_back(eb);
        cyc_q.push_back(cyc);
        m_in_enable = 1'b1;
        m_in        = fix_t'(m_val);
        // w_in is junk past k = 0, the held weight must win
        w_in        = (k == 0) ? fix_t'(w_row) : fix_t'(next_rand());
        // Stray e strobe and start while busy
        if (beat_idx < tc.strays) begin
          e_in_enable = 1'b1;
          e_in        = fix_t'(next_rand());
          start       = 1'b1;
          size_n      = row_cnt_t'(next_rand());
          size_w      = width_t'(next_rand());
        end
        beat_idx++;
      end
    end
    step();
    // Last beat still in the pipe
    check_value("busy while draining", busy, 1);
    waited = 0;
    while (ready_cnt == 0 && waited < READY_TIMEOUT) begin
      @(posedge CLK);
      waited++;
    end
    if (ready_cnt == 0) begin
      $display("ERROR: ready never came within %0d cycles in test %0d", READY_TIMEOUT, t);
      timed_out = 1'b1;
    end else begin
      #1;
      check_value("busy after ready", busy, 0);
      repeat (4) step();
      check_value("ready pulses", ready_cnt, 1);
      check_value("output beats", out_cnt, tc.n * tc.w);
      check_value("beats left over", exp_q.size(), 0);
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin : main
    int err_before;
    RST         = 1'b1;
    start       = 1'b0;
    size_n      = '0;
    size_w      = '0;
    e_in_enable = 1'b0;
    e_in        = '0;
    m_in_enable = 1'b0;
    m_in        = '0;
    w_in        = '0;
    // n, w, value mode, gap pattern, stray strobes of each kind
    tests[0] = '{4, 8, MODE_IN, GAP_NONE, 0};
    tests[1] = '{3, 5, MODE_IN, GAP_RAND, 0};
    tests[2] = '{3, 4, MODE_OUT, GAP_ONE, 0};
    tests[3] = '{2, 8, MODE_EXT, GAP_NONE, 0};
    tests[4] = '{5, 3, MODE_IN, GAP_RAND, 3};
    tests[5] = '{2, 1, MODE_OUT, GAP_NONE, 2};
    tests[6] = '{1, 7, MODE_EXT, GAP_RAND, 1};
    repeat (10) @(posedge CLK);
    #1;
    RST = 1'b0;
    check_value("m_out_enable after reset", m_out_enable, 0);
    check_value("m_out_row_end after reset", m_out_row_end, 0);
    check_value("ready after reset", ready, 0);
    check_value("busy after reset", busy, 0);
    for (int t = 0; t < NUM_TESTS; t++) begin
      err_before = errors;
      run_test(t);
      if (errors == err_before && !timed_out) tests_ok++;
      else tests_bad++;
      $display("test %0d: n=%0d w=%0d mode=%0d gap=%0d strays=%0d, %0d error(s)", t,
               tests[t].n, tests[t].w, tests[t].mode, tests[t].gap, tests[t].strays,
               errors - err_before);
      if (timed_out) break;
    end
    $display("tests ok %0d, tests with errors %0d, total errors %0d",
             tests_ok, tests_bad, errors);
    if (errors == 0 && !timed_out) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sim.f */
verilog/ntm_num_pkg.sv
verilog/ntm_erase_pkg.sv
verilog/erase_sequencer.sv
verilog/erase_vector_store.sv
verilog/erase_weight_stage.sv
verilog/memory_scale_stage.sv
verilog/ntm_erase_top.sv
tests/ntm_erase_tb.sv
